// File: Bender.yml
package:
  name: rename_subsystem

sources:
  - rename_pkg.sv
  - map_table.sv
  - free_list.sv
  - rob_cam.sv
  - rob.sv
  - arch_map.sv
  - rename_top.sv
  - target: test
    files:
      - rename_checker.sv
      - rename_assert.sv
      - rename_tb.sv

// File: arch_map.sv
`timescale 1ns/1ps

module arch_map (
	input  logic                                              clock,
	input  logic                                              rst,
	input  logic                                              retire_valid,
	input  rename_pkg::arch_reg_t                             retire_arch,
	input  rename_pkg::phys_reg_t                             retire_t_new,
	output rename_pkg::phys_reg_t [rename_pkg::num_arch-1:0]  arch_table_next,
	output rename_pkg::phys_mask_t                            in_use_next
);

	rename_pkg::phys_reg_t [rename_pkg::num_arch-1:0] table_q; // Committed map

	// Committed map including this cycle's retire
	always_comb begin
		arch_table_next = table_q;
		if (retire_valid) begin
			arch_table_next[retire_arch] = retire_t_new;
		end
	end

	// Tags held by the committed map, everything else is free after a flush
	always_comb begin
		in_use_next = '0;
		for (int i = 0; i < rename_pkg::num_arch; i++) begin
			in_use_next[arch_table_next[i]] = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < rename_pkg::num_arch; i++) begin
				table_q[i] <= rename_pkg::phys_reg_t'(i);
			end
		end else begin
			table_q <= arch_table_next;
		end
	end

endmodule

// File: compile.f
rename_pkg.sv
map_table.sv
free_list.sv
rob_cam.sv
rob.sv
arch_map.sv
rename_top.sv
rename_checker.sv
rename_assert.sv
rename_tb.sv

// File: free_list.sv
`timescale 1ns/1ps

module free_list (
	input  logic                   clock,
	input  logic                   rst,
	input  logic                   accept,
	input  logic                   release_valid,
	input  rename_pkg::phys_reg_t  release_tag,
	input  logic                   flush,
	input  rename_pkg::phys_mask_t restore_free,
	output rename_pkg::phys_reg_t  alloc_tag,
	output logic                   free_empty
);

	rename_pkg::phys_mask_t free_q; // Set bit means the tag is free
	rename_pkg::phys_mask_t free_next;

	// Priority encoder, lowest free tag wins
	always_comb begin
		alloc_tag = '0;
		for (int i = rename_pkg::num_phys - 1; i >= 0; i--) begin
			if (free_q[i]) begin
				alloc_tag = rename_pkg::phys_reg_t'(i);
			end
		end
	end

	assign free_empty = ~|free_q;

	// A released tag is only visible to the encoder from the next cycle
	always_comb begin
		free_next = free_q;
		if (accept) begin
			free_next[alloc_tag] = 1'b0;
		end
		if (release_valid) begin
			free_next[release_tag] = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			// Upper half free, lower half holds the identity map
			free_q <= {{(rename_pkg::num_phys - rename_pkg::num_arch){1'b1}},
				{rename_pkg::num_arch{1'b0}}};
		end else if (flush) begin
			free_q <= restore_free;
		end else begin
			free_q <= free_next;
		end
	end

endmodule

// File: map_table.sv
`timescale 1ns/1ps

module map_table (
	input  logic                                                clock,
	input  logic                                                rst,
	input  logic                                                accept,
	input  rename_pkg::arch_reg_t                               dispatch_arch,
	input  rename_pkg::phys_reg_t                               alloc_tag,
	input  logic                                                flush,
	input  rename_pkg::phys_reg_t [rename_pkg::num_arch-1:0]    restore_map,
	output rename_pkg::phys_reg_t                               old_tag
);

	// Speculative mapping, one physical tag per architectural register
	rename_pkg::phys_reg_t [rename_pkg::num_arch-1:0] map_q;

	// Previous mapping of the destination, read in the dispatch cycle
	assign old_tag = map_q[dispatch_arch];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < rename_pkg::num_arch; i++) begin
				map_q[i] <= rename_pkg::phys_reg_t'(i); // Identity map
			end
		end else if (flush) begin
			map_q <= restore_map; // Back to the committed state
		end else if (accept) begin
			map_q[dispatch_arch] <= alloc_tag;
		end
	end

endmodule

// File: rename_assert.sv
`timescale 1ns/1ps

module rename_assert (
	input logic                  clock,
	input logic                  rst,
	input logic                  dispatch_valid,
	input logic                  stall,
	input logic                  retire_valid,
	input rename_pkg::phys_reg_t retire_t_new,
	input rename_pkg::phys_reg_t retire_t_old
);

	int fail_count = 0; // Number of failed assertions

	// The dispatcher has to hold off while stalled
	no_dispatch_on_stall: assert property (@(posedge clock) disable iff (rst)
		!(dispatch_valid && stall))
		else begin
			fail_count++;
			$error("dispatch_valid was raised while stall was high");
		end

	retire_tags_differ: assert property (@(posedge clock) disable iff (rst)
		retire_valid |-> (retire_t_new != retire_t_old))
		else begin
			fail_count++;
			$error("retire_t_new equals retire_t_old on a retire");
		end

	no_retire_after_reset: assert property (@(posedge clock) $fell(rst) |-> !retire_valid)
		else begin
			fail_count++;
			$error("retire_valid high in the first cycle after reset");
		end

endmodule

// File: rename_checker.sv
`timescale 1ns/1ps

module rename_checker #(
	parameter int rob_depth = 16
) (
	input  logic                        clock,
	input  logic                        rst,
	input  logic                        dispatch_valid,
	input  rename_pkg::arch_reg_t       dispatch_arch,
	input  logic                        cdb_valid,
	input  rename_pkg::phys_reg_t       cdb_tag,
	input  logic                        flush,
	input  logic                        stall,
	input  rename_pkg::phys_reg_t       t_new,
	input  rename_pkg::phys_reg_t       t_old,
	input  logic                        retire_valid,
	input  rename_pkg::arch_reg_t       retire_arch,
	input  rename_pkg::phys_reg_t       retire_t_new,
	input  rename_pkg::phys_reg_t       retire_t_old,
	input  logic [$clog2(rob_depth):0]  rob_free_entries,
	output int                          check_count,
	output int                          error_count
);

	rename_pkg::phys_reg_t spec_map [rename_pkg::num_arch];
	rename_pkg::phys_reg_t commit_map [rename_pkg::num_arch];
	rename_pkg::phys_mask_t free_mask; // Set bit means free

	// Model ROB, oldest entry at index 0
	rename_pkg::arch_reg_t q_arch [$];
	rename_pkg::phys_reg_t q_new [$];
	rename_pkg::phys_reg_t q_old [$];
	bit q_done [$];

	initial begin
		check_count = 0;
		error_count = 0;
	end

	task automatic compare_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch %s at %0t: expected 0x%0h, got 0x%0h",
				name, $time, expected, actual);
		end
	endtask

	task automatic reset_model();
		free_mask = '0;
		for (int i = 0; i < rename_pkg::num_phys; i++) begin
			if (i < rename_pkg::num_arch) begin
				spec_map[i] = rename_pkg::phys_reg_t'(i);
				commit_map[i] = rename_pkg::phys_reg_t'(i);
			end else begin
				free_mask[i] = 1'b1;
			end
		end
		q_arch.delete();
		q_new.delete();
		q_old.delete();
		q_done.delete();
	endtask

	// Compare this cycle's outputs, then advance the model past the coming edge
	task automatic step_model();
		logic exp_stall;
		logic exp_retire;
		logic accept;
		int depth;
		int tag;
		depth = q_new.size();
		exp_stall = (depth == rob_depth) || (free_mask == '0);
		exp_retire = (depth > 0) && q_done[0];
		accept = dispatch_valid && !exp_stall;
		tag = -1;
		for (int i = rename_pkg::num_phys - 1; i >= 0; i--) begin
			if (free_mask[i]) tag = i;
		end
		compare_value("stall", exp_stall, stall);
		compare_value("rob_free_entries", rob_depth - depth, rob_free_entries);
		compare_value("retire_valid", exp_retire, retire_valid);
		if (exp_retire) begin
			compare_value("retire_arch", q_arch[0], retire_arch);
			compare_value("retire_t_new", q_new[0], retire_t_new);
			compare_value("retire_t_old", q_old[0], retire_t_old);
			commit_map[q_arch[0]] = q_new[0];
			free_mask[q_old[0]] = 1'b1; // Usable from the next cycle
			void'(q_arch.pop_front());
			void'(q_new.pop_front());
			void'(q_old.pop_front());
			void'(q_done.pop_front());
		end
		if (accept) begin
			compare_value("t_new", tag, t_new);
			compare_value("t_old", spec_map[dispatch_arch], t_old);
		end
		if (flush) begin
			// Rebuild from the committed map, retire of this cycle included
			q_arch.delete();
			q_new.delete();
			q_old.delete();
			q_done.delete();
			free_mask = '1;
			for (int i = 0; i < rename_pkg::num_arch; i++) begin
				spec_map[i] = commit_map[i];
				free_mask[commit_map[i]] = 1'b0;
			end
		end else begin
			for (int i = 0; i < q_new.size(); i++) begin
				if (cdb_valid && q_new[i] == cdb_tag) q_done[i] = 1'b1;
			end
			if (accept) begin
				q_arch.push_back(dispatch_arch);
				q_new.push_back(rename_pkg::phys_reg_t'(tag));
				q_old.push_back(spec_map[dispatch_arch]);
				q_done.push_back(1'b0);
				spec_map[dispatch_arch] = rename_pkg::phys_reg_t'(tag);
				free_mask[tag] = 1'b0;
			end
		end
	endtask

	always @(negedge clock) begin
		if (rst) begin
			reset_model();
		end else begin
			step_model();
		end
	end

endmodule

// File: rename_pkg.sv
package rename_pkg;

	// Register file sizes
	localparam int num_arch = 32;
	localparam int num_phys = 64;

	// Architectural register index
	typedef logic [$clog2(num_arch)-1:0] arch_reg_t;

	// Physical register tag
	typedef logic [$clog2(num_phys)-1:0] phys_reg_t;

	// One bit per physical register
	typedef logic [num_phys-1:0] phys_mask_t;

endpackage

// File: rename_tb.sv
`timescale 1ns/1ps

module rename_tb;

	localparam int rob_depth = 16;
	localparam int stim_cycles = 2000;
	localparam int cycle_limit = 4 + stim_cycles + 200; // Reset, stimulus and drain

	logic clock = 1'b0;
	logic rst = 1'b1;
	logic dispatch_valid = 1'b0;
	rename_pkg::arch_reg_t dispatch_arch = '0;
	logic cdb_valid = 1'b0;
	rename_pkg::phys_reg_t cdb_tag = '0;
	logic flush = 1'b0;
	logic stall;
	logic retire_valid;
	rename_pkg::phys_reg_t t_new;
	rename_pkg::phys_reg_t t_old;
	rename_pkg::arch_reg_t retire_arch;
	rename_pkg::phys_reg_t retire_t_new;
	rename_pkg::phys_reg_t retire_t_old;
	logic [$clog2(rob_depth):0] rob_free_entries;
	int check_count;
	int error_count;
	int cycle_count = 0;

	logic [31:0] lfsr = 32'h6ad1_23a5;
	rename_pkg::phys_reg_t pending [$]; // Dispatched tags not yet broadcast

	always #4 clock = ~clock;

	bind rename_top rename_assert assert0 (.*);

	rename_top #(.rob_depth(rob_depth)) dut0 (.*);

	rename_checker #(.rob_depth(rob_depth)) chk0 (.*);

	// Galois LFSR stepped once per bit taken
	task automatic random_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			val = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic print_counts();
		$display("Checks %0d, mismatches %0d, assertion failures %0d",
			check_count, error_count, dut0.assert0.fail_count);
	endtask

	task automatic drive_cycle(input bit draining);
		logic [31:0] r_flush;
		logic [31:0] r_disp;
		logic [31:0] r_arch;
		logic [31:0] r_cdb;
		logic [31:0] r_pick;
		int idx;
		random_bits(6, r_flush);
		random_bits(1, r_disp);
		random_bits(5, r_arch);
		random_bits(1, r_cdb);
		random_bits(5, r_pick);
		flush = !draining && (r_flush == 0); // About one cycle in 64
		dispatch_valid = !draining && !flush && r_disp[0] && !stall;
		dispatch_arch = r_arch[4:0];
		cdb_valid = 1'b0;
		if (!flush && pending.size() > 0 && (draining || r_cdb[0])) begin
			idx = draining ? 0 : int'(r_pick % pending.size());
			cdb_valid = 1'b1;
			cdb_tag = pending[idx];
			pending.delete(idx);
		end
		if (flush) begin
			pending.delete(); // Everything in flight is squashed
		end
		if (dispatch_valid) begin
			pending.push_back(t_new);
		end
	endtask

	initial begin
		repeat (4) @(posedge clock);
		#1 rst = 1'b0;
		for (int c = 0; c < stim_cycles; c++) begin
			@(posedge clock);
			#1 drive_cycle(1'b0);
		end
		// Complete every outstanding tag and let the ROB empty
		while (pending.size() > 0 || rob_free_entries != rob_depth) begin
			@(posedge clock);
			#1 drive_cycle(1'b1);
		end
		repeat (2) @(posedge clock);
		print_counts();
		if (error_count == 0 && dut0.assert0.fail_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the ROB did not drain", cycle_count);
			print_counts();
			$display("TB FAILED");
			$finish;
		end
	end

endmodule

// File: rename_top.sv
`timescale 1ns/1ps

module rename_top #(
	parameter int rob_depth = 16
) (
	input  logic                        clock,
	input  logic                        rst,
	input  logic                        dispatch_valid,
	input  rename_pkg::arch_reg_t       dispatch_arch,
	input  logic                        cdb_valid,
	input  rename_pkg::phys_reg_t       cdb_tag,
	input  logic                        flush,
	output logic                        stall,
	output rename_pkg::phys_reg_t       t_new,
	output rename_pkg::phys_reg_t       t_old,
	output logic                        retire_valid,
	output rename_pkg::arch_reg_t       retire_arch,
	output rename_pkg::phys_reg_t       retire_t_new,
	output rename_pkg::phys_reg_t       retire_t_old,
	output logic [$clog2(rob_depth):0]  rob_free_entries
);

	logic accept;
	logic rob_full;
	logic free_empty;
	rename_pkg::phys_reg_t alloc_tag;
	rename_pkg::phys_reg_t old_tag;
	rename_pkg::phys_reg_t [rename_pkg::num_arch-1:0] arch_table_next;
	rename_pkg::phys_mask_t in_use_next;

	assign stall = rob_full | free_empty;
	assign accept = dispatch_valid & ~stall;
	assign t_new = alloc_tag;
	assign t_old = old_tag;

	map_table map0 (
		.clock        (clock),
		.rst          (rst),
		.accept       (accept),
		.dispatch_arch(dispatch_arch),
		.alloc_tag    (alloc_tag),
		.flush        (flush),
		.restore_map  (arch_table_next),
		.old_tag      (old_tag)
	);

	free_list free0 (
		.clock        (clock),
		.rst          (rst),
		.accept       (accept),
		.release_valid(retire_valid),
		.release_tag  (retire_t_old),
		.flush        (flush),
		.restore_free (~in_use_next), // Anything not committed is free
		.alloc_tag    (alloc_tag),
		.free_empty   (free_empty)
	);

	rob #(
		.rob_depth(rob_depth)
	) rob0 (
		.clock           (clock),
		.rst             (rst),
		.accept          (accept),
		.dispatch_arch   (dispatch_arch),
		.t_new_in        (alloc_tag),
		.t_old_in        (old_tag),
		.cdb_valid       (cdb_valid),
		.cdb_tag         (cdb_tag),
		.flush           (flush),
		.rob_full        (rob_full),
		.rob_free_entries(rob_free_entries),
		.retire_valid    (retire_valid),
		.retire_arch     (retire_arch),
		.retire_t_new    (retire_t_new),
		.retire_t_old    (retire_t_old)
	);

	arch_map amap0 (
		.clock          (clock),
		.rst            (rst),
		.retire_valid   (retire_valid),
		.retire_arch    (retire_arch),
		.retire_t_new   (retire_t_new),
		.arch_table_next(arch_table_next),
		.in_use_next    (in_use_next)
	);

endmodule

// File: rob.sv
`timescale 1ns/1ps

module rob #(
	parameter int rob_depth = 16
) (
	input  logic                        clock,
	input  logic                        rst,
	input  logic                        accept,
	input  rename_pkg::arch_reg_t       dispatch_arch,
	input  rename_pkg::phys_reg_t       t_new_in,
	input  rename_pkg::phys_reg_t       t_old_in,
	input  logic                        cdb_valid,
	input  rename_pkg::phys_reg_t       cdb_tag,
	input  logic                        flush,
	output logic                        rob_full,
	output logic [$clog2(rob_depth):0]  rob_free_entries,
	output logic                        retire_valid,
	output rename_pkg::arch_reg_t       retire_arch,
	output rename_pkg::phys_reg_t       retire_t_new,
	output rename_pkg::phys_reg_t       retire_t_old
);

	localparam int idx_w = $clog2(rob_depth);
	localparam int cnt_w = idx_w + 1;

	logic [rob_depth-1:0] valid_q;
	logic [rob_depth-1:0] complete_q;
	logic [rob_depth-1:0] hit;

	// Entry payload
	rename_pkg::arch_reg_t [rob_depth-1:0] arch_q;
	rename_pkg::phys_reg_t [rob_depth-1:0] t_new_q;
	rename_pkg::phys_reg_t [rob_depth-1:0] t_old_q;

	logic [idx_w-1:0] head_q; // Oldest entry
	logic [idx_w-1:0] tail_q; // Next free slot
	logic [cnt_w-1:0] count_q;

	rob_cam #(
		.rob_depth(rob_depth)
	) cam0 (
		.cdb_valid  (cdb_valid),
		.cdb_tag    (cdb_tag),
		.entry_valid(valid_q),
		.entry_tag  (t_new_q),
		.hit        (hit)
	);

	assign rob_full = (count_q == cnt_w'(rob_depth));
	assign rob_free_entries = cnt_w'(rob_depth) - count_q;

	// Head retires as soon as its result has been broadcast
	assign retire_valid = valid_q[head_q] & complete_q[head_q];
	assign retire_arch = arch_q[head_q];
	assign retire_t_new = t_new_q[head_q];
	assign retire_t_old = t_old_q[head_q];

	always_ff @(posedge clock) begin
		if (rst || flush) begin
			valid_q <= '0;
			complete_q <= '0;
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
		end else begin
			complete_q <= complete_q | hit;
			if (retire_valid) begin
				valid_q[head_q] <= 1'b0;
				complete_q[head_q] <= 1'b0;
				head_q <= head_q + 1'b1; // Wraps at rob_depth
			end
			if (accept) begin
				valid_q[tail_q] <= 1'b1;
				complete_q[tail_q] <= 1'b0;
				tail_q <= tail_q + 1'b1;
			end
			case ({accept, retire_valid})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q; // Both or neither
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept && !flush) begin
			arch_q[tail_q] <= dispatch_arch;
			t_new_q[tail_q] <= t_new_in;
			t_old_q[tail_q] <= t_old_in;
		end
	end

endmodule

// File: rob_cam.sv
`timescale 1ns/1ps

module rob_cam #(
	parameter int rob_depth = 16
) (
	input  logic                                   cdb_valid,
	input  rename_pkg::phys_reg_t                  cdb_tag,
	input  logic [rob_depth-1:0]                   entry_valid,
	input  rename_pkg::phys_reg_t [rob_depth-1:0]  entry_tag,
	output logic [rob_depth-1:0]                   hit
);

	// Parallel compare of the broadcast against every t_new
	always_comb begin
		hit = '0;
		if (cdb_valid) begin
			for (int i = 0; i < rob_depth; i++) begin
				hit[i] = entry_valid[i] && (entry_tag[i] == cdb_tag);
			end
		end
	end

endmodule
